/* sim.f */
+incdir+include
rtl/axi_adapter_pkg.sv
rtl/axi_write_tracker.sv
rtl/axi_req_issue.sv
rtl/tag_index_buffer.sv
rtl/axi_adapter.sv
verif/axi_adapter_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the adapter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module axi_adapter_tb -o sim_axi_adapter

./obj_dir/sim_axi_adapter | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
    exit 1
fi

exit 0

/* verif/axi_adapter_tb.sv */
// Testbench for the memory request to AXI adapter
// AXI memory model with out-of-order reads, reference function, compare tasks

`timescale 1ns/1ps

`include "axi_adapter_defines.svh"

module axi_adapter_tb import axi_adapter_pkg::*; ();

    logic      clk;
    logic      rst;
    logic      mem_req_valid;
    logic      mem_req_ready;
    req_op_e   mem_req_op;
    mem_addr_t mem_req_addr;
    byteen_t   mem_req_byteen;
    data_t     mem_req_data;
    mem_tag_t  mem_req_tag;
    logic      mem_rsp_valid;
    logic      mem_rsp_ready;
    data_t     mem_rsp_data;
    mem_tag_t  mem_rsp_tag;
    logic      m_axi_awvalid;
    logic      m_axi_awready;
    logic      m_axi_wvalid;
    logic      m_axi_wready;
    logic      m_axi_arvalid;
    logic      m_axi_arready;
    logic      m_axi_rvalid;
    logic      m_axi_rready;
    axi_addr_t m_axi_awaddr;
    axi_addr_t m_axi_araddr;
    axi_id_t   m_axi_awid;
    axi_id_t   m_axi_arid;
    axi_id_t   m_axi_rid;
    data_t     m_axi_wdata;
    data_t     m_axi_rdata;
    byteen_t   m_axi_wstrb;

    integer    seed = 32'h4a74103d;
    int        errors = 0;
    int        tests = 0;
    int        writes_applied = 0;
    int        aw_count = 0;
    int        w_count = 0;
    bit        hold_r = 0;
    bit        split_mode = 0;

    data_t     mem [axi_addr_t];
    data_t     ref_mem [mem_addr_t];
    data_t     exp_by_tag [mem_tag_t];
    axi_addr_t aw_q[$];
    data_t     wdata_q[$];
    byteen_t   wstrb_q[$];
    axi_addr_t ar_addr_q[$];
    axi_id_t   ar_id_q[$];
    mem_tag_t  ar_tag_q[$];
    mem_tag_t  cur_tag;
    int        cur_idx;

    axi_adapter u_axi_adapter (.*);

    initial begin
        clk = 0;
        forever #50 clk = ~clk;
    end

    // Merges writes under byte enables and returns the current word
    function automatic data_t expected_read(bit wr, mem_addr_t addr, data_t data, byteen_t be);
        data_t word;
        word = ref_mem.exists(addr) ? ref_mem[addr] : '0;
        if (wr) begin
            for (int b = 0; b < `AXI_DATA_SIZE; b++) begin
                if (be[b]) begin
                    word[b*8 +: 8] = data[b*8 +: 8];
                end
            end
            ref_mem[addr] = word;
        end
        return word;
    endfunction

    task automatic check_data(data_t got, data_t exp, string msg);
        if (got !== exp) begin
            $display("FAIL %0t: %s data got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(mem_tag_t got, mem_tag_t exp, string msg);
        if (got !== exp) begin
            $display("FAIL %0t: %s tag got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(axi_addr_t got, axi_addr_t exp, string msg);
        if (got !== exp) begin
            $display("FAIL %0t: %s addr got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_id(axi_id_t got, axi_id_t exp, string msg);
        if (got !== exp) begin
            $display("FAIL %0t: %s id got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    // Random slave readiness with W opposite to AW in split mode
    always @(posedge clk) begin
        bit split;
        split = split_mode;
        #1;
        m_axi_awready = 1'($random(seed));
        m_axi_wready  = split ? !m_axi_awready : 1'($random(seed));
        m_axi_arready = 1'($random(seed));
        mem_rsp_ready = 1'($random(seed));
    end

    // AXI memory model, address checks and write application
    always @(posedge clk) begin
        if (!rst && m_axi_awvalid && m_axi_awready) begin
            check_addr(m_axi_awaddr, {6'b0, mem_req_addr} * 8, "awaddr");
            check_id(m_axi_awid, axi_id_t'(mem_req_tag % 16), "awid");
            aw_q.push_back(m_axi_awaddr);
            aw_count++;
        end
        if (!rst && m_axi_wvalid && m_axi_wready) begin
            wdata_q.push_back(m_axi_wdata);
            wstrb_q.push_back(m_axi_wstrb);
            w_count++;
        end
        while (aw_q.size() > 0 && wdata_q.size() > 0) begin
            data_t w;
            axi_addr_t a;
            byteen_t s;
            a = aw_q.pop_front();
            w = wdata_q.pop_front();
            s = wstrb_q.pop_front();
            if (!mem.exists(a)) begin
                mem[a] = '0;
            end
            for (int b = 0; b < `AXI_DATA_SIZE; b++) begin
                if (s[b]) begin
                    mem[a][b*8 +: 8] = w[b*8 +: 8];
                end
            end
            writes_applied++;
        end
        if (!rst && m_axi_arvalid && m_axi_arready) begin
            check_addr(m_axi_araddr, {6'b0, mem_req_addr} * 8, "araddr");
            ar_addr_q.push_back(m_axi_araddr);
            ar_id_q.push_back(m_axi_arid);
            ar_tag_q.push_back(mem_req_tag);
        end
        // Each write completes after exactly one AW and one W
        if (!rst && mem_req_valid && mem_req_ready && mem_req_op == OP_WRITE) begin
            if (aw_count != 1 || w_count != 1) begin
                $display("FAIL %0t: write accepted after %0d AW and %0d W handshakes",
                         $time, aw_count, w_count);
                errors++;
            end
            aw_count = 0;
            w_count = 0;
        end
    end

    // R channel answers queued reads in random order
    always @(posedge clk) begin
        bit fire;
        bit hold;
        fire = m_axi_rvalid && m_axi_rready;
        hold = hold_r;
        #1;
        if (fire) begin
            ar_addr_q.delete(cur_idx);
            ar_id_q.delete(cur_idx);
            ar_tag_q.delete(cur_idx);
            m_axi_rvalid = 0;
        end
        if (!m_axi_rvalid && !hold && ar_addr_q.size() > 0) begin
            cur_idx = $unsigned($random(seed)) % ar_addr_q.size();
            m_axi_rvalid = 1;
            m_axi_rid = ar_id_q[cur_idx];
            cur_tag = ar_tag_q[cur_idx];
            m_axi_rdata = mem.exists(ar_addr_q[cur_idx]) ? mem[ar_addr_q[cur_idx]] : '0;
        end
    end

    // Compares every response with the reference
    always @(posedge clk) begin
        if (!rst && mem_rsp_valid && mem_rsp_ready) begin
            check_tag(mem_rsp_tag, cur_tag, "response");
            if (exp_by_tag.exists(cur_tag)) begin
                check_data(mem_rsp_data, exp_by_tag[cur_tag], "response");
                exp_by_tag.delete(cur_tag);
            end else begin
                $display("response arrived for tag %h that was never requested", cur_tag);
                errors++;
            end
        end
    end

    task automatic send_req(req_op_e op, mem_addr_t addr, data_t data, byteen_t be,
                            mem_tag_t tag);
        int n;
        if (op == OP_WRITE) begin
            void'(expected_read(1, addr, data, be));
        end else begin
            exp_by_tag[tag] = expected_read(0, addr, '0, '0);
        end
        mem_req_valid = 1;
        mem_req_op = op;
        mem_req_addr = addr;
        mem_req_data = data;
        mem_req_byteen = be;
        mem_req_tag = tag;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!mem_req_ready && n < 2000);
        if (!mem_req_ready) begin
            $display("timeout waiting for request acceptance");
            errors++;
        end
        #1;
        mem_req_valid = 0;
    endtask

    task automatic wait_responses();
        int n;
        n = 0;
        while (exp_by_tag.num() > 0 && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (exp_by_tag.num() > 0) begin
            $display("timeout waiting for response");
            errors++;
        end
        #1;
    endtask

    task automatic report(string name, int err_before);
        tests++;
        $display("test %0d %s: %s", tests, name, errors == err_before ? "ok" : "errors");
    endtask

    initial begin
        int e;
        int wa;
        rst = 1;
        mem_req_valid = 0;
        mem_req_op = OP_READ;
        mem_req_addr = '0;
        mem_req_byteen = '0;
        mem_req_data = '0;
        mem_req_tag = '0;
        mem_rsp_ready = 0;
        m_axi_awready = 0;
        m_axi_wready = 0;
        m_axi_arready = 0;
        m_axi_rvalid = 0;
        m_axi_rdata = '0;
        m_axi_rid = '0;
        repeat (5) @(posedge clk);
        #1 rst = 0;

        e = errors;
        send_req(OP_WRITE, 26'h3ffffff, 64'h1122334455667788, 8'hff, 8'h01);
        send_req(OP_WRITE, 26'h0000123, 64'hcafef00d12345678, 8'hff, 8'h02);
        send_req(OP_READ, 26'h3ffffff, '0, '0, 8'h03);
        send_req(OP_READ, 26'h2aaaaaa, '0, '0, 8'h04);
        wait_responses();
        report("address conversion", e);

        e = errors;
        send_req(OP_WRITE, 26'h40, 64'h0, 8'hff, 8'h10);
        send_req(OP_WRITE, 26'h40, 64'haaaaaaaaaaaaaaaa, 8'h0f, 8'h11);
        send_req(OP_WRITE, 26'h40, 64'h5555555555555555, 8'h30, 8'h12);
        send_req(OP_WRITE, 26'h40, 64'hdeadbeefdeadbeef, 8'h81, 8'h13);
        send_req(OP_READ, 26'h40, '0, '0, 8'h14);
        wait_responses();
        report("byte-enable writes", e);

        e = errors;
        for (int i = 0; i < 16; i++) begin
            send_req(OP_WRITE, mem_addr_t'(26'h100 + i), {8{8'(i * 7)}}, 8'hff, 8'h20);
        end
        for (int i = 0; i < 16; i++) begin
            send_req(OP_READ, mem_addr_t'(26'h100 + i), '0, '0, 8'hc0 + 8'(i * 3));
        end
        wait_responses();
        report("tag restoration", e);

        e = errors;
        hold_r = 1;
        for (int i = 0; i < 16; i++) begin
            send_req(OP_READ, mem_addr_t'(26'h100 + i), '0, '0, 8'h60 + 8'(i));
        end
        send_req(OP_WRITE, 26'h200, 64'h0123456789abcdef, 8'hff, 8'h30);
        exp_by_tag[8'h90] = expected_read(0, 26'h200, '0, '0);
        mem_req_valid = 1;
        mem_req_op = OP_READ;
        mem_req_addr = 26'h200;
        mem_req_tag = 8'h90;
        repeat (10) begin
            @(posedge clk);
            if (mem_req_ready) begin
                $display("FAIL %0t: read accepted while tag buffer full", $time);
                errors++;
            end
        end
        #1 hold_r = 0;
        mem_req_valid = 0;
        send_req(OP_READ, 26'h200, '0, '0, 8'h90);
        wait_responses();
        report("tag buffer full", e);

        e = errors;
        split_mode = 1;
        wa = writes_applied;
        for (int i = 0; i < 8; i++) begin
            send_req(OP_WRITE, mem_addr_t'(26'h300 + i), {4{16'(i)}}, 8'hff, 8'h40);
        end
        if (writes_applied - wa != 8) begin
            $display("FAIL %0t: split writes applied %0d expected 8", $time,
                     writes_applied - wa);
            errors++;
        end
        split_mode = 0;
        for (int i = 0; i < 8; i++) begin
            send_req(OP_READ, mem_addr_t'(26'h300 + i), '0, '0, 8'h50 + 8'(i));
        end
        wait_responses();
        report("split write acceptance", e);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* rtl/axi_adapter.sv */
// Memory request to AXI adapter top level
// Request issue, write tracker, tag buffer and read response path

`timescale 1ns/1ps

module axi_adapter import axi_adapter_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // Memory request
    input  logic      mem_req_valid,
    input  req_op_e   mem_req_op,
    input  mem_addr_t mem_req_addr,
    input  byteen_t   mem_req_byteen,
    input  data_t     mem_req_data,
    input  mem_tag_t  mem_req_tag,
    output logic      mem_req_ready,

    // Memory response
    output logic      mem_rsp_valid,
    output data_t     mem_rsp_data,
    output mem_tag_t  mem_rsp_tag,
    input  logic      mem_rsp_ready,

    output logic      m_axi_awvalid,
    input  logic      m_axi_awready,
    output axi_addr_t m_axi_awaddr,
    output axi_id_t   m_axi_awid,

    output logic      m_axi_wvalid,
    input  logic      m_axi_wready,
    output data_t     m_axi_wdata,
    output byteen_t   m_axi_wstrb,

    output logic      m_axi_arvalid,
    input  logic      m_axi_arready,
    output axi_addr_t m_axi_araddr,
    output axi_id_t   m_axi_arid,

    input  logic      m_axi_rvalid,
    output logic      m_axi_rready,
    input  data_t     m_axi_rdata,
    input  axi_id_t   m_axi_rid
);

    logic    write_req;
    logic    aw_done;
    logic    w_done;
    logic    write_done;
    logic    slot_free;
    axi_id_t alloc_id;
    logic    read_fire;
    logic    rsp_fire;

    assign write_req = mem_req_valid && (mem_req_op == OP_WRITE);
    assign rsp_fire  = m_axi_rvalid && mem_rsp_ready;

    // Write payload goes straight to W
    assign m_axi_wdata = mem_req_data;
    assign m_axi_wstrb = mem_req_byteen;

    axi_req_issue u_req_issue (
        .mem_req_valid (mem_req_valid),
        .mem_req_op    (mem_req_op),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag),
        .aw_done       (aw_done),
        .w_done        (w_done),
        .write_done    (write_done),
        .slot_free     (slot_free),
        .alloc_id      (alloc_id),
        .m_axi_arready (m_axi_arready),
        .mem_req_ready (mem_req_ready),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awid    (m_axi_awid),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_araddr  (m_axi_araddr),
        .m_axi_arid    (m_axi_arid),
        .read_fire     (read_fire)
    );

    axi_write_tracker u_write_tracker (
        .clk           (clk),
        .rst           (rst),
        .write_req     (write_req),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .aw_done       (aw_done),
        .w_done        (w_done),
        .write_done    (write_done)
    );

    tag_index_buffer u_tag_buffer (
        .clk         (clk),
        .rst         (rst),
        .alloc_en    (read_fire),
        .alloc_tag   (mem_req_tag),
        .release_en  (rsp_fire),
        .release_id  (m_axi_rid),
        .slot_free   (slot_free),
        .alloc_id    (alloc_id),
        .release_tag (mem_rsp_tag)
    );

    // R channel passes through, only the tag is restored
    assign mem_rsp_valid = m_axi_rvalid;
    assign mem_rsp_data  = m_axi_rdata;
    assign m_axi_rready  = mem_rsp_ready;

endmodule

/* rtl/tag_index_buffer.sv */
// Tag index buffer
// Allocates AXI IDs for reads and holds the original request tags

`timescale 1ns/1ps

`include "axi_adapter_defines.svh"

module tag_index_buffer import axi_adapter_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     alloc_en,
    input  mem_tag_t alloc_tag,
    input  logic     release_en,
    input  axi_id_t  release_id,
    output logic     slot_free,
    output axi_id_t  alloc_id,
    output mem_tag_t release_tag
);

    logic [`TAG_BUFFER_SIZE-1:0] slot_valid;
    mem_tag_t                    tag_mem [`TAG_BUFFER_SIZE];

    assign slot_free = ~(&slot_valid);

    // Lowest free slot wins
    always_comb begin
        alloc_id = '0;
        for (int i = `TAG_BUFFER_SIZE - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                alloc_id = axi_id_t'(i);
            end
        end
    end

    // A slot being allocated is free, so it never collides with a release
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= '0;
        end else begin
            if (alloc_en) begin
                slot_valid[alloc_id] <= 1'b1;
            end
            if (release_en) begin
                slot_valid[release_id] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            tag_mem[alloc_id] <= alloc_tag;
        end
    end

    // Combinational lookup at the responding ID
    assign release_tag = tag_mem[release_id];

endmodule

/* rtl/axi_req_issue.sv */
// Request issue logic
// Steers a memory request onto AW/W or AR, forms byte address and ID

`timescale 1ns/1ps

`include "axi_adapter_defines.svh"

module axi_req_issue import axi_adapter_pkg::*; (
    input  logic      mem_req_valid,
    input  req_op_e   mem_req_op,
    input  mem_addr_t mem_req_addr,
    input  mem_tag_t  mem_req_tag,
    input  logic      aw_done,
    input  logic      w_done,
    input  logic      write_done,
    input  logic      slot_free,
    input  axi_id_t   alloc_id,
    input  logic      m_axi_arready,
    output logic      mem_req_ready,
    output logic      m_axi_awvalid,
    output axi_addr_t m_axi_awaddr,
    output axi_id_t   m_axi_awid,
    output logic      m_axi_wvalid,
    output logic      m_axi_arvalid,
    output axi_addr_t m_axi_araddr,
    output axi_id_t   m_axi_arid,
    output logic      read_fire
);

    logic      is_write;
    axi_addr_t byte_addr;

    assign is_write = (mem_req_op == OP_WRITE);

    // Word address to byte address, upper bits zero
    assign byte_addr = axi_addr_t'(mem_req_addr) << `AXI_LOG2_DATA_SIZE;

    // Channels already accepted for this write stay low
    assign m_axi_awvalid = mem_req_valid && is_write && !aw_done;
    assign m_axi_wvalid  = mem_req_valid && is_write && !w_done;
    assign m_axi_awaddr  = byte_addr;

    // Writes bypass the tag buffer
    assign m_axi_awid = mem_req_tag[`AXI_ID_WIDTH-1:0];

    // Reads wait for a free tag slot
    assign m_axi_arvalid = mem_req_valid && !is_write && slot_free;
    assign m_axi_araddr  = byte_addr;
    assign m_axi_arid    = alloc_id;

    assign read_fire = m_axi_arvalid && m_axi_arready;

    always_comb begin
        if (is_write) begin
            mem_req_ready = write_done;
        end else begin
            mem_req_ready = m_axi_arready && slot_free;
        end
    end

endmodule

/* rtl/axi_write_tracker.sv */
// Write acceptance tracker
// Records AW and W handshakes that land in different cycles

`timescale 1ns/1ps

module axi_write_tracker import axi_adapter_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic write_req,
    input  logic m_axi_awvalid,
    input  logic m_axi_awready,
    input  logic m_axi_wvalid,
    input  logic m_axi_wready,
    output logic aw_done,
    output logic w_done,
    output logic write_done
);

    wr_state_e state;
    wr_state_e state_next;
    logic      aw_fire;
    logic      w_fire;

    assign aw_fire = m_axi_awvalid && m_axi_awready;
    assign w_fire  = m_axi_wvalid && m_axi_wready;

    assign aw_done = (state == WR_AW_DONE);
    assign w_done  = (state == WR_W_DONE);

    // Second half accepted, or both halves in the same cycle
    assign write_done = write_req
                     && (((state == WR_BOTH_PENDING) && aw_fire && w_fire)
                      || ((state == WR_AW_DONE) && w_fire)
                      || ((state == WR_W_DONE) && aw_fire));

    always_comb begin
        state_next = state;
        case (state)
            WR_BOTH_PENDING: begin
                if (write_req && aw_fire && !w_fire) begin
                    state_next = WR_AW_DONE;
                end else if (write_req && w_fire && !aw_fire) begin
                    state_next = WR_W_DONE;
                end
            end
            WR_AW_DONE: begin
                if (w_fire) begin
                    state_next = WR_BOTH_PENDING;
                end
            end
            WR_W_DONE: begin
                if (aw_fire) begin
                    state_next = WR_BOTH_PENDING;
                end
            end
            default: state_next = WR_BOTH_PENDING;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WR_BOTH_PENDING;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* rtl/axi_adapter_pkg.sv */
// Shared types for the AXI adapter
// Data, address, tag and ID types, opcode and write state enums

package axi_adapter_pkg;

    `include "axi_adapter_defines.svh"

    typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
    typedef logic [`AXI_DATA_SIZE-1:0]  byteen_t;
    typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [`MEM_TAG_WIDTH-1:0]  mem_tag_t;

    // Also the tag buffer slot index
    typedef logic [`AXI_ID_WIDTH-1:0]   axi_id_t;

    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

    // Which half of the current write the slave has taken
    typedef enum logic [1:0] {
        WR_BOTH_PENDING = 2'd0,
        WR_AW_DONE      = 2'd1,
        WR_W_DONE       = 2'd2
    } wr_state_e;

endpackage

/* include/axi_adapter_defines.svh */
// Width and size macros for the memory request to AXI adapter
// Data path, address, tag and ID widths

`ifndef AXI_ADAPTER_DEFINES_SVH
`define AXI_ADAPTER_DEFINES_SVH

// Data word
`define AXI_DATA_WIDTH      64
`define AXI_DATA_SIZE       8
`define AXI_LOG2_DATA_SIZE  3

// Word address in, byte address out
`define MEM_ADDR_WIDTH      26
`define AXI_ADDR_WIDTH      32

// Request tag is wider than the AXI ID
`define MEM_TAG_WIDTH       8
`define AXI_ID_WIDTH        4

// One slot per AXI ID value
`define TAG_BUFFER_SIZE     (1 << `AXI_ID_WIDTH)

`endif
